//--- dmem_bank.sv
`timescale 1ns/10ps

`include "rv32i_macros.svh"

module dmem_bank (
    input   logic                           clk,
    input   logic                           we,
    input   logic                           re,
    input   logic   [`DMEM_DEPTH_LOG2-1:0]  addr,
    input   logic   [7:0]                   wdata,
    output  logic   [7:0]                   rdata
);

    localparam int DEPTH = 1 << `DMEM_DEPTH_LOG2;

    logic   [7:0]   mem [DEPTH];

    // one byte per word of the data memory.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read data holds until the next read.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- load_align.sv
`timescale 1ns/10ps

`include "rv32i_macros.svh"

module load_align (
    input   logic                   clk,
    input   logic                   reset,

    input   logic                   mw_valid,
    input   logic   [`XLEN-1:0]     mw_pc,
    input   rv32i_types::mem_op_e   mw_mem_op,
    input   logic   [1:0]           mw_byte_off,
    input   logic   [`XLEN-1:0]     mw_alu_out,
    input   logic   [4:0]           mw_rd_s,
    input   logic                   mw_misaligned,
    input   logic   [`XLEN-1:0]     dmem_rdata,

    output  logic                   wb_valid,
    output  logic   [`XLEN-1:0]     wb_pc,
    output  logic   [4:0]           wb_rd_s,
    output  logic                   wb_we,
    output  logic   [`XLEN-1:0]     wb_rd_v,
    output  logic                   wb_misaligned
);

    import rv32i_types::*;

    logic   [`XLEN-1:0]     shifted;
    logic   [`XLEN-1:0]     load_v;
    logic   [`XLEN-1:0]     result;
    logic                   writes_rd;

    // ##############################
    // load extract
    // ##############################

    assign shifted = dmem_rdata >> {mw_byte_off, 3'b000};  // addressed byte to lane 0.

    always_comb begin
        case (mw_mem_op)
            MEM_LB:  load_v = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
            MEM_LBU: load_v = {{(`XLEN-8){1'b0}}, shifted[7:0]};
            MEM_LH:  load_v = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
            MEM_LHU: load_v = {{(`XLEN-16){1'b0}}, shifted[15:0]};
            MEM_LW:  load_v = shifted;
            default: load_v = '0;
        endcase
    end

    assign result = (mw_mem_op == MEM_NONE) ? mw_alu_out : load_v;

    // stores and x0 never write rd.
    assign writes_rd = mw_valid && !mw_misaligned && (mw_rd_s != 5'd0) &&
                       (is_load(mw_mem_op) || (mw_mem_op == MEM_NONE));

    // ##############################
    // writeback register
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid      <= 1'b0;
            wb_we         <= 1'b0;
            wb_misaligned <= 1'b0;
            wb_rd_v       <= '0;
        end else begin
            wb_valid      <= mw_valid;
            wb_we         <= writes_rd;
            wb_misaligned <= mw_valid && mw_misaligned;
            wb_rd_v       <= writes_rd ? result : '0;  // zero when no write.
        end
    end

    always_ff @(posedge clk) begin
        wb_pc   <= mw_pc;
        wb_rd_s <= mw_rd_s;
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/10ps

`include "rv32i_macros.svh"

module mem_stage (
    input   logic                           clk,
    input   logic                           reset,

    input   logic                           ex_valid,
    input   logic   [`XLEN-1:0]             ex_pc,
    input   rv32i_types::mem_op_e           ex_mem_op,
    input   logic   [`XLEN-1:0]             ex_alu_out,
    input   logic   [`XLEN-1:0]             ex_rs2_v,
    input   logic   [4:0]                   ex_rd_s,

    output  logic   [`DMEM_DEPTH_LOG2-1:0]  dmem_addr,
    output  logic   [`NUM_LANES-1:0]        dmem_rmask,
    output  logic   [`NUM_LANES-1:0]        dmem_wmask,
    output  logic   [`XLEN-1:0]             dmem_wdata,

    output  logic                           mw_valid,
    output  logic   [`XLEN-1:0]             mw_pc,
    output  rv32i_types::mem_op_e           mw_mem_op,
    output  logic   [1:0]                   mw_byte_off,
    output  logic   [`XLEN-1:0]             mw_alu_out,
    output  logic   [4:0]                   mw_rd_s,
    output  logic                           mw_misaligned
);

    import rv32i_types::*;

    logic   [1:0]               byte_off;
    logic   [`NUM_LANES-1:0]    size_mask;
    logic   [`NUM_LANES-1:0]    lane_mask;
    logic                       misaligned;

    // ##############################
    // access decode
    // ##############################

    assign byte_off  = ex_alu_out[1:0];
    assign dmem_addr = ex_alu_out[`DMEM_DEPTH_LOG2+1:2];  // upper bits dropped, wraps.

    always_comb begin
        size_mask  = '0;
        misaligned = 1'b0;
        case (ex_mem_op)
            MEM_LB, MEM_LBU, MEM_SB: begin
                size_mask = 4'b0001;
            end
            MEM_LH, MEM_LHU, MEM_SH: begin
                size_mask  = 4'b0011;
                misaligned = byte_off[0];  // odd halfword.
            end
            MEM_LW, MEM_SW: begin
                size_mask  = 4'b1111;
                misaligned = (byte_off != 2'd0);
            end
            default: begin
                size_mask  = '0;  // no access.
                misaligned = 1'b0;
            end
        endcase
    end

    // lanes move up with the byte offset.
    assign lane_mask = (ex_valid && !misaligned) ? (size_mask << byte_off) : '0;

    assign dmem_rmask = is_load(ex_mem_op) ? lane_mask : '0;
    assign dmem_wmask = is_store(ex_mem_op) ? lane_mask : '0;

    // store data lands on the enabled lanes.
    assign dmem_wdata = ex_rs2_v << {byte_off, 3'b000};

    // ##############################
    // mem/wb register
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            mw_valid      <= 1'b0;
            mw_misaligned <= 1'b0;
        end else begin
            mw_valid      <= ex_valid;
            mw_misaligned <= ex_valid && misaligned;
        end
    end

    always_ff @(posedge clk) begin
        mw_pc       <= ex_pc;
        mw_mem_op   <= ex_mem_op;
        mw_byte_off <= byte_off;  // picks the load bytes.
        mw_alu_out  <= ex_alu_out;
        mw_rd_s     <= ex_rd_s;
    end

endmodule

//--- mem_top.f
+incdir+.
rv32i_types.sv
dmem_bank.sv
mem_stage.sv
load_align.sv
mem_top.sv
tb_clock_gen.sv
tb_mem_top.sv

//--- mem_top.sv
`timescale 1ns/10ps

`include "rv32i_macros.svh"

module mem_top (
    input   logic                   clk,
    input   logic                   reset,

    input   logic                   ex_valid,
    input   logic   [`XLEN-1:0]     ex_pc,
    input   rv32i_types::mem_op_e   ex_mem_op,
    input   logic   [`XLEN-1:0]     ex_alu_out,
    input   logic   [`XLEN-1:0]     ex_rs2_v,
    input   logic   [4:0]           ex_rd_s,

    output  logic                   wb_valid,
    output  logic   [`XLEN-1:0]     wb_pc,
    output  logic   [4:0]           wb_rd_s,
    output  logic                   wb_we,
    output  logic   [`XLEN-1:0]     wb_rd_v,
    output  logic                   wb_misaligned
);

    import rv32i_types::*;

    // bank bus.
    logic   [`DMEM_DEPTH_LOG2-1:0]  dmem_addr;
    logic   [`NUM_LANES-1:0]        dmem_rmask;
    logic   [`NUM_LANES-1:0]        dmem_wmask;
    logic   [`XLEN-1:0]             dmem_wdata;
    logic   [`XLEN-1:0]             dmem_rdata;

    // mem/wb stage signals.
    logic                           mw_valid;
    logic   [`XLEN-1:0]             mw_pc;
    mem_op_e                        mw_mem_op;
    logic   [1:0]                   mw_byte_off;
    logic   [`XLEN-1:0]             mw_alu_out;
    logic   [4:0]                   mw_rd_s;
    logic                           mw_misaligned;

    mem_stage i_mem_stage (
        .clk           (clk),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_mem_op     (ex_mem_op),
        .ex_alu_out    (ex_alu_out),
        .ex_rs2_v      (ex_rs2_v),
        .ex_rd_s       (ex_rd_s),
        .dmem_addr     (dmem_addr),
        .dmem_rmask    (dmem_rmask),
        .dmem_wmask    (dmem_wmask),
        .dmem_wdata    (dmem_wdata),
        .mw_valid      (mw_valid),
        .mw_pc         (mw_pc),
        .mw_mem_op     (mw_mem_op),
        .mw_byte_off   (mw_byte_off),
        .mw_alu_out    (mw_alu_out),
        .mw_rd_s       (mw_rd_s),
        .mw_misaligned (mw_misaligned)
    );

    // one bank per byte lane.
    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        dmem_bank i_dmem_bank (
            .clk   (clk),
            .we    (dmem_wmask[i]),
            .re    (dmem_rmask[i]),
            .addr  (dmem_addr),
            .wdata (dmem_wdata[8*i +: 8]),
            .rdata (dmem_rdata[8*i +: 8])
        );
    end

    load_align i_load_align (
        .clk           (clk),
        .reset         (reset),
        .mw_valid      (mw_valid),
        .mw_pc         (mw_pc),
        .mw_mem_op     (mw_mem_op),
        .mw_byte_off   (mw_byte_off),
        .mw_alu_out    (mw_alu_out),
        .mw_rd_s       (mw_rd_s),
        .mw_misaligned (mw_misaligned),
        .dmem_rdata    (dmem_rdata),
        .wb_valid      (wb_valid),
        .wb_pc         (wb_pc),
        .wb_rd_s       (wb_rd_s),
        .wb_we         (wb_we),
        .wb_rd_v       (wb_rd_v),
        .wb_misaligned (wb_misaligned)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the mem_top testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_mem_top \
    -f mem_top.f \
    -o tb_mem_top_sim > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "verilator build failed"; exit 1; }

./obj_dir/tb_mem_top_sim > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "TEST FAILED" "$SIM_LOG" && { echo "simulation reported failure"; exit 1; } \
    || grep -q "TEST PASSED" "$SIM_LOG" \
    || { echo "no result found in $SIM_LOG"; exit 1; }

exit 0

//--- rv32i_macros.svh
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// ##############################
// datapath
// ##############################

// data and address width.
`define XLEN 32

// ##############################
// data memory
// ##############################

// log2 of the word count, 256 words.
`define DMEM_DEPTH_LOG2 8

// byte lanes per word.
`define NUM_LANES 4

`endif

//--- rv32i_types.sv
package rv32i_types;

    // ##############################
    // memory opcodes
    // ##############################

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,  // no access, alu result to rd.
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    function automatic logic is_load(mem_op_e op);
        logic result;
        case (op)
            MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU: result = 1'b1;
            default:                                  result = 1'b0;
        endcase
        return result;
    endfunction

    function automatic logic is_store(mem_op_e op);
        logic result;
        case (op)
            MEM_SB, MEM_SH, MEM_SW: result = 1'b1;
            default:                result = 1'b0;
        endcase
        return result;
    endfunction

endpackage

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output  logic   clk
);

    localparam real HALF_PERIOD = 2.0;  // 4 ns period.

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD) clk = ~clk;
    end

endmodule

//--- tb_mem_top.sv
`timescale 1ns/10ps

`include "rv32i_macros.svh"

module tb_mem_top;

    import rv32i_types::*;

    // tests take about 400 cycles, fill included.
    localparam int MAX_CYCLES = 2000;

    typedef struct packed {
        logic           valid;
        logic   [31:0]  pc;
        logic   [4:0]   rd;
        logic           we;
        logic   [31:0]  rd_v;
        logic           mis;
    } wb_exp_t;

    logic               clk;
    logic               reset;
    logic               ex_valid;
    logic   [31:0]      ex_pc;
    mem_op_e            ex_mem_op;
    logic   [31:0]      ex_alu_out;
    logic   [31:0]      ex_rs2_v;
    logic   [4:0]       ex_rd_s;
    logic               wb_valid;
    logic   [31:0]      wb_pc;
    logic   [4:0]       wb_rd_s;
    logic               wb_we;
    logic   [31:0]      wb_rd_v;
    logic               wb_misaligned;

    logic   [7:0]       model_mem [1024];  // byte address space, wraps at 1 KiB.
    wb_exp_t            exp_pipe [2];      // slot 1 is due at this edge.
    logic   [31:0]      next_pc;
    int                 errors;
    int                 tests_passed;
    int                 tests_failed;
    int                 cycle_count = 0;

    tb_clock_gen i_clock_gen (
        .clk (clk)
    );

    mem_top i_mem_top (
        .clk           (clk),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_mem_op     (ex_mem_op),
        .ex_alu_out    (ex_alu_out),
        .ex_rs2_v      (ex_rs2_v),
        .ex_rd_s       (ex_rd_s),
        .wb_valid      (wb_valid),
        .wb_pc         (wb_pc),
        .wb_rd_s       (wb_rd_s),
        .wb_we         (wb_we),
        .wb_rd_v       (wb_rd_v),
        .wb_misaligned (wb_misaligned)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ##############################
    // reference model and checks
    // ##############################

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_wb(input wb_exp_t e);
        compare_value("wb_valid", 32'(e.valid), 32'(wb_valid));
        compare_value("wb_we", 32'(e.we), 32'(wb_we));
        compare_value("wb_misaligned", 32'(e.mis), 32'(wb_misaligned));
        compare_value("wb_rd_v", e.rd_v, wb_rd_v);
        if (e.valid) begin
            compare_value("wb_pc", e.pc, wb_pc);
            compare_value("wb_rd_s", 32'(e.rd), 32'(wb_rd_s));
        end
    endtask

    task automatic model_access(input logic valid, input logic [31:0] pc, input mem_op_e op,
                                input logic [31:0] alu, input logic [31:0] rs2,
                                input logic [4:0] rd, output wb_exp_t e);
        logic   [9:0]   a;
        logic           mis;
        logic           load;
        logic   [31:0]  word_v;
        logic   [31:0]  load_v;
        a = alu[9:0];
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: mis = alu[0];
            MEM_LW, MEM_SW:          mis = (alu[1:0] != 2'd0);
            default:                 mis = 1'b0;
        endcase
        load = (op == MEM_LB) || (op == MEM_LH) || (op == MEM_LW) ||
               (op == MEM_LBU) || (op == MEM_LHU);
        word_v = {model_mem[a + 10'd3], model_mem[a + 10'd2],
                  model_mem[a + 10'd1], model_mem[a]};  // bytes from the address up.
        case (op)
            MEM_LB:  load_v = {{24{word_v[7]}}, word_v[7:0]};
            MEM_LBU: load_v = {24'd0, word_v[7:0]};
            MEM_LH:  load_v = {{16{word_v[15]}}, word_v[15:0]};
            MEM_LHU: load_v = {16'd0, word_v[15:0]};
            default: load_v = word_v;
        endcase
        if (valid && !mis) begin
            if (op == MEM_SB || op == MEM_SH || op == MEM_SW) begin
                model_mem[a] = rs2[7:0];
            end
            if (op == MEM_SH || op == MEM_SW) begin
                model_mem[a + 10'd1] = rs2[15:8];
            end
            if (op == MEM_SW) begin
                model_mem[a + 10'd2] = rs2[23:16];
                model_mem[a + 10'd3] = rs2[31:24];
            end
        end
        e.valid = valid;
        e.pc    = pc;
        e.rd    = rd;
        e.mis   = valid && mis;
        e.we    = valid && !mis && (rd != 5'd0) && (load || op == MEM_NONE);
        e.rd_v  = e.we ? ((op == MEM_NONE) ? alu : load_v) : 32'd0;
    endtask

    // one cycle: check the result due now, then drive the next slot.
    task automatic step(input logic valid, input mem_op_e op, input logic [31:0] alu,
                        input logic [31:0] rs2, input logic [4:0] rd);
        wb_exp_t e;
        @(negedge clk);
        check_wb(exp_pipe[1]);
        exp_pipe[1] = exp_pipe[0];
        model_access(valid, next_pc, op, alu, rs2, rd, e);
        exp_pipe[0] = e;
        ex_valid   = valid;
        ex_pc      = next_pc;
        ex_mem_op  = op;
        ex_alu_out = alu;
        ex_rs2_v   = rs2;
        ex_rd_s    = rd;
        if (valid) begin
            next_pc = next_pc + 32'd4;
        end
    endtask

    task automatic issue(input mem_op_e op, input logic [31:0] alu, input logic [31:0] rs2,
                         input logic [4:0] rd);
        step(1'b1, op, alu, rs2, rd);
    endtask

    task automatic drain();
        repeat (3) step(1'b0, MEM_NONE, 32'd0, 32'd0, 5'd0);  // flush both stages.
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%s: pass", name);
            tests_passed++;
        end else begin
            $display("%s: fail, %0d mismatches", name, errors - err_before);
            tests_failed++;
        end
    endtask

    function automatic mem_op_e pick_op(input logic [3:0] k);
        case (k)
            4'd0:    return MEM_NONE;
            4'd1:    return MEM_LB;
            4'd2:    return MEM_LH;
            4'd3:    return MEM_LW;
            4'd4:    return MEM_LBU;
            4'd5:    return MEM_LHU;
            4'd6:    return MEM_SB;
            4'd7:    return MEM_SH;
            default: return MEM_SW;
        endcase
    endfunction

    // ##############################
    // directed tests
    // ##############################

    task automatic reset_and_alu();
        int err_before;
        err_before = errors;
        compare_value("wb_valid", 32'd0, 32'(wb_valid));
        compare_value("wb_we", 32'd0, 32'(wb_we));
        issue(MEM_NONE, 32'h1234_5678, 32'd0, 5'd5);
        issue(MEM_NONE, 32'hcafe_0001, 32'd0, 5'd0);  // x0, no write.
        drain();
        report_test("reset_and_alu", err_before);
    endtask

    task automatic word_store_load();
        int             err_before;
        logic   [31:0]  addr [8];
        err_before = errors;
        for (int i = 0; i < 8; i++) begin
            addr[i] = $urandom & 32'h0000_03fc;
            issue(MEM_SW, addr[i], $urandom, 5'd0);
            issue(MEM_LW, addr[i], 32'd0, 5'd10);  // reads the store of the last cycle.
        end
        for (int i = 0; i < 8; i++) begin
            issue(MEM_LW, addr[i], 32'd0, 5'(i + 1));
        end
        drain();
        report_test("word_store_load", err_before);
    endtask

    task automatic byte_half_loads();
        int             err_before;
        logic   [31:0]  base;
        err_before = errors;
        issue(MEM_SW, 32'h0000_0040, 32'h80ff_7f01, 5'd0);
        issue(MEM_SW, 32'h0000_0044, 32'h7f80_01fe, 5'd0);
        for (int w = 0; w < 2; w++) begin
            base = 32'h0000_0040 + 32'(4 * w);
            for (int k = 0; k < 4; k++) begin
                issue(MEM_LB, base + 32'(k), 32'd0, 5'd7);
                issue(MEM_LBU, base + 32'(k), 32'd0, 5'd8);
            end
            for (int k = 0; k < 4; k += 2) begin
                issue(MEM_LH, base + 32'(k), 32'd0, 5'd9);
                issue(MEM_LHU, base + 32'(k), 32'd0, 5'd11);
            end
        end
        drain();
        report_test("byte_half_loads", err_before);
    endtask

    task automatic partial_stores();
        int err_before;
        err_before = errors;
        for (int k = 0; k < 4; k++) begin
            issue(MEM_SW, 32'h0000_0100, 32'hdead_beef, 5'd0);
            issue(MEM_SB, 32'h0000_0100 + 32'(k), 32'h1234_56a5, 5'd0);
            issue(MEM_LW, 32'h0000_0100, 32'd0, 5'd12);
        end
        for (int k = 0; k < 4; k += 2) begin
            issue(MEM_SW, 32'h0000_0104, 32'h0f1e_2d3c, 5'd0);
            issue(MEM_SH, 32'h0000_0104 + 32'(k), 32'h9988_c3b4, 5'd0);
            issue(MEM_LW, 32'h0000_0104, 32'd0, 5'd13);
        end
        drain();
        report_test("partial_stores", err_before);
    endtask

    task automatic misaligned_access();
        int err_before;
        err_before = errors;
        issue(MEM_SW, 32'h0000_0200, 32'h0bad_f00d, 5'd0);
        for (int k = 1; k < 4; k += 2) begin
            issue(MEM_LH, 32'h0000_0200 + 32'(k), 32'd0, 5'd14);
            issue(MEM_SH, 32'h0000_0200 + 32'(k), 32'h5555_aaaa, 5'd0);
        end
        for (int k = 1; k < 4; k++) begin
            issue(MEM_LW, 32'h0000_0200 + 32'(k), 32'd0, 5'd15);
            issue(MEM_SW, 32'h0000_0200 + 32'(k), 32'h1357_9bdf, 5'd0);
        end
        issue(MEM_LW, 32'h0000_0200, 32'd0, 5'd16);  // still the first word.
        drain();
        report_test("misaligned_access", err_before);
    endtask

    task automatic throughput_wrap();
        int err_before;
        err_before = errors;
        for (int w = 0; w < 256; w++) begin
            issue(MEM_SW, 32'(w * 4), (32'h9e37_79b9 * 32'(w + 1)) ^ 32'(w), 5'd0);
        end
        issue(MEM_SW, 32'h0001_0408, 32'h600d_cafe, 5'd0);  // aliases word 2.
        issue(MEM_LW, 32'h0000_0008, 32'd0, 5'd17);
        for (int i = 0; i < 40; i++) begin
            issue(pick_op(4'($urandom_range(8, 0))), $urandom, $urandom, 5'($urandom));
        end
        drain();
        report_test("throughput_wrap", err_before);
    endtask

    // ##############################
    // main sequence
    // ##############################

    initial begin
        void'($urandom(32'h68c3_3025));
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        next_pc      = 32'h0000_1000;
        reset        = 1'b1;
        ex_valid     = 1'b0;
        ex_pc        = 32'd0;
        ex_mem_op    = MEM_NONE;
        ex_alu_out   = 32'd0;
        ex_rs2_v     = 32'd0;
        ex_rd_s      = 5'd0;
        for (int i = 0; i < 1024; i++) begin
            model_mem[i] = 8'd0;
        end
        for (int i = 0; i < 2; i++) begin
            exp_pipe[i] = '0;  // nothing in flight.
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_and_alu();
        word_store_load();
        byte_half_loads();
        partial_stores();
        misaligned_access();
        throughput_wrap();

        $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
